/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_core
FLIST     = flist.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir

/* commit.sv */
// Commit stage
// Architectural register file, result writeback and the store port
// toward data memory

`timescale 1ns/10ps

module commit (
    input  logic                           clk,
    input  logic                           rst_n,
    // From execute stage register
    input  logic                           in_val,
    output logic                           in_rdy,
    input  core_pkg::writeback_packet_t    in_packet,
    // Read ports for execute
    input  logic [core_pkg::REG_BITS-1:0]  rs1_idx,
    input  logic [core_pkg::REG_BITS-1:0]  rs2_idx,
    output logic [core_pkg::XLEN-1:0]      rs1_data,
    output logic [core_pkg::XLEN-1:0]      rs2_data,
    // Data memory request
    input  logic                           dmem_req_rdy,
    output logic                           dmem_req_val,
    output core_pkg::store_req_t           dmem_req_packet
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            store;
    logic            retire;

    // x0 reads as zero
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    // Stores wait for data memory, everything else retires at once
    assign store           = in_val && in_packet.is_store;
    assign dmem_req_val    = store;
    assign dmem_req_packet = '{addr: in_packet.store_addr, data: in_packet.store_data};
    assign in_rdy          = !store || dmem_req_rdy;
    assign retire          = in_val && in_rdy;

    // Registers start at zero like the ISA reset state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire && in_packet.writes_rd && (in_packet.rd != '0)) begin
            regs[in_packet.rd] <= in_packet.result;
        end
    end

endmodule

/* core.sv */
// Core top level
// Fetch, decode, execute and commit joined by three stage registers

`timescale 1ns/10ps

module core (
    input  logic                       clk,
    input  logic                       rst_n,
    // Instruction memory
    input  logic                       imem_req_rdy,
    output logic                       imem_req_val,
    output logic [core_pkg::XLEN-1:0]  imem_req_packet,
    output logic                       imem_rec_rdy,
    input  logic                       imem_rec_val,
    input  logic [core_pkg::XLEN-1:0]  imem_rec_packet,
    // Data memory stores
    input  logic                       dmem_req_rdy,
    output logic                       dmem_req_val,
    output core_pkg::store_req_t       dmem_req_packet
);
    import core_pkg::*;

    // ------------------------------
    // Fetch
    // ------------------------------
    logic              fetch_val;
    logic              fetch_rdy;
    fetch_packet_t     fetch_pkt;
    logic              fq_val;
    logic              fq_rdy;
    fetch_packet_t     fq_pkt;

    fetch fetch_stage (
        .clk(clk), .rst_n(rst_n),
        .imem_req_rdy(imem_req_rdy), .imem_req_val(imem_req_val),
        .imem_req_packet(imem_req_packet),
        .imem_rec_rdy(imem_rec_rdy), .imem_rec_val(imem_rec_val),
        .imem_rec_packet(imem_rec_packet),
        .out_val(fetch_val), .out_rdy(fetch_rdy), .out_packet(fetch_pkt)
    );

    pipe_reg #(.payload_t(fetch_packet_t)) fetch_q (
        .clk(clk), .rst_n(rst_n),
        .in_val(fetch_val), .in_rdy(fetch_rdy), .in_data(fetch_pkt),
        .out_val(fq_val), .out_rdy(fq_rdy), .out_data(fq_pkt)
    );

    // ------------------------------
    // Decode
    // ------------------------------
    instruction_t      dec_inst;
    logic              dq_val;
    logic              dq_rdy;
    instruction_t      dq_inst;

    decode decode_stage (.in_packet(fq_pkt), .out_inst(dec_inst));

    pipe_reg #(.payload_t(instruction_t)) decode_q (
        .clk(clk), .rst_n(rst_n),
        .in_val(fq_val), .in_rdy(fq_rdy), .in_data(dec_inst),
        .out_val(dq_val), .out_rdy(dq_rdy), .out_data(dq_inst)
    );

    // ------------------------------
    // Execute
    // ------------------------------
    logic [REG_BITS-1:0] rs1_idx;
    logic [REG_BITS-1:0] rs2_idx;
    logic [XLEN-1:0]     rs1_data;
    logic [XLEN-1:0]     rs2_data;
    writeback_packet_t   exec_result;
    logic                xq_val;
    logic                xq_rdy;
    writeback_packet_t   xq_pkt;

    // Forwarding source is the packet now at commit
    execute execute_stage (
        .inst(dq_inst),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .fwd_packet(xq_pkt), .fwd_val(xq_val),
        .result(exec_result)
    );

    pipe_reg #(.payload_t(writeback_packet_t)) exec_q (
        .clk(clk), .rst_n(rst_n),
        .in_val(dq_val), .in_rdy(dq_rdy), .in_data(exec_result),
        .out_val(xq_val), .out_rdy(xq_rdy), .out_data(xq_pkt)
    );

    // ------------------------------
    // Commit
    // ------------------------------
    commit commit_stage (
        .clk(clk), .rst_n(rst_n),
        .in_val(xq_val), .in_rdy(xq_rdy), .in_packet(xq_pkt),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .dmem_req_rdy(dmem_req_rdy), .dmem_req_val(dmem_req_val),
        .dmem_req_packet(dmem_req_packet)
    );

endmodule

/* core_pkg.sv */
// Core package
// RV32I subset constants, widths and the packed packets that move
// between the pipeline stages

package core_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_BITS = 5;

    // ------------------------------
    // ISA encodings
    // ------------------------------
    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 values shared by register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Instruction bit that turns ADD into SUB
    localparam int F7_SUB_BIT = 30;

    // ALU operations, pass-B carries the LUI immediate
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    // ------------------------------
    // Stage packets
    // ------------------------------
    // Fetch to decode
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_packet_t;

    // Decode to execute
    typedef struct packed {
        alu_op_e             alu_op;
        logic [REG_BITS-1:0] rd;
        logic [REG_BITS-1:0] rs1;
        logic [REG_BITS-1:0] rs2;
        logic [XLEN-1:0]     imm;
        logic                use_imm;
        logic                writes_rd;
        logic                is_store;
    } instruction_t;

    // Execute to commit
    typedef struct packed {
        logic [REG_BITS-1:0] rd;
        logic                writes_rd;
        logic [XLEN-1:0]     result;
        logic                is_store;
        logic [XLEN-1:0]     store_addr;
        logic [XLEN-1:0]     store_data;
    } writeback_packet_t;

    // Data memory store request
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } store_req_t;

endpackage

/* core_sva.sv */
// Core port checks
// Handshake stability, quiet ports in reset and a single outstanding fetch

`timescale 1ns/10ps

module core_sva (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       imem_req_rdy,
    input logic                       imem_req_val,
    input logic [core_pkg::XLEN-1:0]  imem_req_packet,
    input logic                       imem_rec_rdy,
    input logic                       imem_rec_val,
    input logic                       dmem_req_rdy,
    input logic                       dmem_req_val,
    input core_pkg::store_req_t       dmem_req_packet
);

    int unsigned fail_cnt = 0;
    logic        outstanding;

    // Set by a request transfer, cleared by the matching response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (imem_req_val && imem_req_rdy) begin
            outstanding <= 1'b1;
        end else if (imem_rec_val && imem_rec_rdy) begin
            outstanding <= 1'b0;
        end
    end

    imem_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_val && !imem_req_rdy |=> imem_req_val && $stable(imem_req_packet))
        else begin
            $error("imem request dropped or changed before its handshake");
            fail_cnt++;
        end

    dmem_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req_val && !dmem_req_rdy |=> dmem_req_val && $stable(dmem_req_packet))
        else begin
            $error("dmem store dropped or changed before its handshake");
            fail_cnt++;
        end

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !imem_req_val && !dmem_req_val)
        else begin
            $error("memory request raised while in reset");
            fail_cnt++;
        end

    one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding |-> !imem_req_val)
        else begin
            $error("second imem request issued while one is outstanding");
            fail_cnt++;
        end

endmodule

/* decode.sv */
// Decode stage
// Turns an RV32I subset instruction into a micro-op with its immediate
// Anything outside the subset decodes to a no-op

`timescale 1ns/10ps

module decode (
    input  core_pkg::fetch_packet_t in_packet,
    output core_pkg::instruction_t  out_inst
);
    import core_pkg::*;

    logic [XLEN-1:0] inst;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    alu_op_e         f3_op;
    logic            f3_ok;

    assign inst   = in_packet.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    // Sign-extended I and S immediates
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    // Upper immediate
    assign imm_u = {inst[31:12], 12'b0};

    // funct3 to ALU op
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            F3_ADD_SUB: begin
                // SUB exists only in register form
                f3_op = (opcode == OPC_OP && inst[F7_SUB_BIT]) ? ALU_SUB : ALU_ADD;
            end
            F3_XOR:  f3_op = ALU_XOR;
            F3_OR:   f3_op = ALU_OR;
            F3_AND:  f3_op = ALU_AND;
            default: begin
                f3_op = ALU_ADD;
                f3_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        // No-op unless an opcode below matches
        out_inst        = '0;
        out_inst.alu_op = ALU_ADD;
        out_inst.rd     = inst[11:7];
        out_inst.rs1    = inst[19:15];
        out_inst.rs2    = inst[24:20];
        case (opcode)
            OPC_OP: begin
                out_inst.alu_op    = f3_op;
                out_inst.writes_rd = f3_ok;
            end
            OPC_OP_IMM: begin
                out_inst.alu_op    = f3_op;
                out_inst.imm       = imm_i;
                out_inst.use_imm   = 1'b1;
                out_inst.writes_rd = f3_ok;
            end
            OPC_LUI: begin
                out_inst.alu_op    = ALU_PASS_B;
                out_inst.rs1       = '0;
                out_inst.imm       = imm_u;
                out_inst.use_imm   = 1'b1;
                out_inst.writes_rd = 1'b1;
            end
            OPC_STORE: begin
                // Address is rs1 + imm through the ALU
                out_inst.imm      = imm_s;
                out_inst.use_imm  = 1'b1;
                out_inst.is_store = 1'b1;
            end
            default: ;
        endcase
        // x0 never becomes a destination, so it is never forwarded
        if (out_inst.rd == '0) begin
            out_inst.writes_rd = 1'b0;
        end
    end

endmodule

/* execute.sv */
// Execute stage
// Operand select with forwarding from the commit packet, the ALU,
// and store address and data generation

`timescale 1ns/10ps

module execute (
    input  core_pkg::instruction_t         inst,
    // Register file read
    output logic [core_pkg::REG_BITS-1:0]  rs1_idx,
    output logic [core_pkg::REG_BITS-1:0]  rs2_idx,
    input  logic [core_pkg::XLEN-1:0]      rs1_data,
    input  logic [core_pkg::XLEN-1:0]      rs2_data,
    // Packet waiting in commit
    input  core_pkg::writeback_packet_t    fwd_packet,
    input  logic                           fwd_val,
    // To commit
    output core_pkg::writeback_packet_t    result
);
    import core_pkg::*;

    logic            fwd_rs1;
    logic            fwd_rs2;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;

    assign rs1_idx = inst.rs1;
    assign rs2_idx = inst.rs2;

    // Commit writes this cycle, so the register file is still stale
    assign fwd_rs1 = fwd_val && fwd_packet.writes_rd && (fwd_packet.rd == inst.rs1);
    assign fwd_rs2 = fwd_val && fwd_packet.writes_rd && (fwd_packet.rd == inst.rs2);

    assign op_a    = fwd_rs1 ? fwd_packet.result : rs1_data;
    assign rs2_val = fwd_rs2 ? fwd_packet.result : rs2_data;
    assign op_b    = inst.use_imm ? inst.imm : rs2_val;

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (inst.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // Stores reuse the adder for rs1 + imm and send rs2 as data
    assign result = '{
        rd:         inst.rd,
        writes_rd:  inst.writes_rd,
        result:     alu_out,
        is_store:   inst.is_store,
        store_addr: alu_out,
        store_data: rs2_val
    };

endmodule

/* fetch.sv */
// Fetch stage
// Sequential PC, one outstanding instruction memory request,
// and pairing of each returned instruction with its PC

`timescale 1ns/10ps

module fetch (
    input  logic                       clk,
    input  logic                       rst_n,
    // Instruction memory request
    input  logic                       imem_req_rdy,
    output logic                       imem_req_val,
    output logic [core_pkg::XLEN-1:0]  imem_req_packet,
    // Instruction memory response
    output logic                       imem_rec_rdy,
    input  logic                       imem_rec_val,
    input  logic [core_pkg::XLEN-1:0]  imem_rec_packet,
    // To decode
    output logic                       out_val,
    input  logic                       out_rdy,
    output core_pkg::fetch_packet_t    out_packet
);
    import core_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] req_pc;
    logic            pending;
    logic            running;
    logic            req_fire;
    logic            rec_fire;

    // No new request while a response is still due
    assign imem_req_val    = running && !pending;
    assign imem_req_packet = pc;
    assign req_fire        = imem_req_val && imem_req_rdy;

    // Response goes straight into the fetch stage register
    assign imem_rec_rdy = out_rdy;
    assign out_val      = imem_rec_val && pending;
    assign rec_fire     = out_val && imem_rec_rdy;
    assign out_packet   = '{pc: req_pc, inst: imem_rec_packet};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            pending <= 1'b0;
            pc      <= '0;
        end else begin
            // Starts requesting one cycle out of reset
            running <= 1'b1;
            if (req_fire) begin
                pc      <= pc + XLEN'(4);
                pending <= 1'b1;
            end else if (rec_fire) begin
                pending <= 1'b0;
            end
        end
    end

    // PC of the request in flight
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_pc <= pc;
        end
    end

endmodule

/* flist.f */
core_pkg.sv
pipe_reg.sv
fetch.sv
decode.sv
execute.sv
commit.sv
core.sv
core_sva.sv
tb_core.sv

/* pipe_reg.sv */
// Pipeline stage register
// One-entry rdy/val buffer, the payload type is set per instance

`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    // Upstream side
    input  logic     in_val,
    output logic     in_rdy,
    input  payload_t in_data,
    // Downstream side
    output logic     out_val,
    input  logic     out_rdy,
    output payload_t out_data
);

    // Accept when empty or when the held entry leaves this cycle
    assign in_rdy = !out_val || out_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_val <= 1'b0;
        end else if (in_rdy) begin
            out_val <= in_val;
        end
    end

    // Payload only moves on an input transfer
    always_ff @(posedge clk) begin
        if (in_val && in_rdy) begin
            out_data <= in_data;
        end
    end

endmodule

/* tb_core.sv */
// Core testbench
// Runs a fixed RV32I program twice, once with fixed memory latency and once with
// random memory stalls, and checks every store against an ISA model

`timescale 1ns/10ps

module tb_core;
    import core_pkg::*;

    logic              clk;
    logic              rst_n;
    logic              imem_req_rdy;
    logic              imem_req_val;
    logic [XLEN-1:0]   imem_req_packet;
    logic              imem_rec_rdy;
    logic              imem_rec_val;
    logic [XLEN-1:0]   imem_rec_packet;
    logic              dmem_req_rdy;
    logic              dmem_req_val;
    store_req_t        dmem_req_packet;

    // Memory model state
    logic              stall;
    string             pass_name;
    logic              busy;
    int                delay;
    logic [XLEN-1:0]   rsp_addr;
    logic [XLEN-1:0]   req_addr;
    logic              in_rst;
    logic              req_xfer;
    logic              rsp_xfer;
    int                store_age;
    logic              st_val;
    logic              st_xfer;

    // Expected stores in program order
    store_req_t        exp_q[$];
    string             tag_q[$];
    int                mismatch_cnt = 0;
    int                unexpected_cnt = 0;

    // Program, word index = PC / 4
    logic [31:0] prog [31] = '{
        32'h06400093, 32'hFF900113,   // addi x1,x0,100   addi x2,x0,-7
        32'h002081B3, 32'h00302023,   // add x3,x1,x2     sw x3,0(x0)
        32'h40208233, 32'h00402223,   // sub x4,x1,x2     sw x4,4(x0)
        32'h0020F2B3, 32'h00502423,   // and x5,x1,x2     sw x5,8(x0)
        32'h0020E333, 32'h00602623,   // or x6,x1,x2      sw x6,12(x0)
        32'h0020C3B3, 32'h00702823,   // xor x7,x1,x2     sw x7,16(x0)
        32'hED408413, 32'h00802A23,   // addi x8,x1,-300  sw x8,20(x0)
        32'h00300493, 32'h009484B3,   // addi x9,x0,3     add x9,x9,x9
        32'h40148533, 32'h00954533,   // sub x10,x9,x1    xor x10,x10,x9
        32'h00A02C23, 32'h10000593,   // sw x10,24(x0)    addi x11,x0,256
        32'h00A5A223, 32'h03700013,   // sw x10,4(x11)    addi x0,x0,55
        32'h00208033, 32'h00002E23,   // add x0,x1,x2     sw x0,28(x0)
        32'h12345637, 32'h67860613,   // lui x12,0x12345  addi x12,x12,0x678
        32'h000016B7, 32'hFEC6AE23,   // lui x13,1        sw x12,-4(x13)
        32'hFFFFF737, 32'hFFF70713,   // lui x14,0xfffff  addi x14,x14,-1
        32'h7EE6AFA3                  // sw x14,2047(x13)
    };

    core DUT (.*);

    bind core core_sva core_checks (.*);

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic string test_of(input int idx);
        if (idx < 14) return "alu_ops";
        if (idx < 21) return "dep_chain";
        if (idx < 24) return "x0_zero";
        return "lui_store";
    endfunction

    // Runs the program on an architectural model, queues each SW
    function automatic void build_expected();
        logic [31:0] x [32];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        store_req_t  st;
        exp_q.delete();
        tag_q.delete();
        foreach (x[i]) x[i] = '0;
        foreach (prog[i]) begin
            w = prog[i];
            a = x[w[19:15]];
            // Register operand for OP, I immediate otherwise
            b = (w[6:0] == 7'h33) ? x[w[24:20]] : {{20{w[31]}}, w[31:20]};
            case (w[14:12])
                3'd0:    r = (w[6:0] == 7'h33 && w[30]) ? a - b : a + b;
                3'd4:    r = a ^ b;
                3'd6:    r = a | b;
                default: r = a & b;
            endcase
            if (w[6:0] == 7'h37) r = {w[31:12], 12'h000};
            if (w[6:0] == 7'h23) begin
                st.addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                st.data = x[w[24:20]];
                exp_q.push_back(st);
                tag_q.push_back(test_of(i));
            end else if (w[6:0] inside {7'h33, 7'h13, 7'h37} && w[11:7] != 5'd0) begin
                x[w[11:7]] = r;
            end
        end
    endfunction

    // Past the program the memory answers with addi x0,x0,0
    function automatic logic [31:0] imem_word(input logic [31:0] addr);
        int unsigned idx;
        idx = addr >> 2;
        return (idx < $size(prog)) ? prog[idx[4:0]] : 32'h00000013;
    endfunction

    task automatic print_counts(input int missing);
        $display("Error counts: mismatched %0d, unexpected %0d, missing %0d, assertion %0d",
                 mismatch_cnt, unexpected_cnt, missing, DUT.core_checks.fail_cnt);
    endtask

    // ------------------------------
    // Clock and memory models
    // ------------------------------
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        void'($urandom(32'hd62581dd));
        rst_n           = 1'b0;
        imem_req_rdy    = 1'b0;
        imem_rec_val    = 1'b0;
        imem_rec_packet = '0;
        dmem_req_rdy    = 1'b0;
        busy            = 1'b0;
        delay           = 0;
        rsp_addr        = '0;
        store_age       = 0;
        forever begin
            // Handshakes are settled by the falling edge
            @(negedge clk);
            in_rst   = !rst_n;
            req_xfer = imem_req_val && imem_req_rdy;
            rsp_xfer = imem_rec_val && imem_rec_rdy;
            req_addr = imem_req_packet;
            st_val   = dmem_req_val;
            st_xfer  = dmem_req_val && dmem_req_rdy;
            @(posedge clk);
            #1;
            if (in_rst || rsp_xfer) begin
                busy         = 1'b0;
                imem_rec_val = 1'b0;
            end
            if (!in_rst && req_xfer) begin
                busy     = 1'b1;
                rsp_addr = req_addr;
                delay    = stall ? int'($urandom % 4) : 0;
            end
            // Response held until fetch takes it
            if (busy && !imem_rec_val) begin
                if (delay == 0) begin
                    imem_rec_val    = 1'b1;
                    imem_rec_packet = imem_word(rsp_addr);
                end else begin
                    delay--;
                end
            end
            // Cycles the current store has waited on data memory
            if (in_rst || st_xfer || !st_val) begin
                store_age = 0;
            end else begin
                store_age++;
            end
            imem_req_rdy = stall ? (($urandom % 4) != 0) : 1'b1;
            // Fixed latency holds each store three cycles, so the
            // instructions behind it close up and meet in execute
            dmem_req_rdy = stall ? (($urandom % 2) != 0) : (store_age >= 3);
        end
    end

    // ------------------------------
    // Store checker
    // ------------------------------
    task automatic check_store(input store_req_t got);
        store_req_t want;
        string      name;
        assert (exp_q.size() != 0) else begin
            $display("Store to %h arrived after every expected store was seen", got.addr);
            unexpected_cnt++;
        end
        if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            name = tag_q.pop_front();
            assert (got == want) else begin
                $display("[FAIL] %s/%s: expected addr %h data %h, actual addr %h data %h",
                         pass_name, name, want.addr, want.data, got.addr, got.data);
                mismatch_cnt++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && dmem_req_val && dmem_req_rdy) begin
            check_store(dmem_req_packet);
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    task automatic run_pass(input logic random_stalls, input string name);
        @(negedge clk);
        stall     = random_stalls;
        pass_name = name;
        @(posedge clk);
        #1 rst_n = 1'b0;
        build_expected();
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        while (exp_q.size() != 0) @(posedge clk);
        // Room for any extra store to show up
        repeat (20) @(posedge clk);
    endtask

    initial begin
        run_pass(1'b0, "fixed_latency");
        run_pass(1'b1, "random_stall");
        print_counts(exp_q.size());
        if (mismatch_cnt + unexpected_cnt + DUT.core_checks.fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Two passes, generous per-instruction budget
    initial begin
        int limit;
        limit = 2 * ($size(prog) * 20 + 200);
        repeat (limit) @(posedge clk);
        $display("Watchdog expired with %0d expected stores still missing", exp_q.size());
        print_counts(exp_q.size());
        $display("Result: FAILED");
        $finish;
    end

endmodule
